//--- Bender.yml
package:
  name: busmaster

sources:
  # RTL, package and interface first
  - design/busmaster_pkg.sv
  - design/wb_if.sv
  - design/wb_priarbiter.sv
  - design/wb_busdelay.sv
  - design/wb_interconnect.sv
  - design/blk_ram.sv
  - design/fastio.sv
  - design/busmaster.sv

  # Testbench, top module busmaster_tb
  - target: test
    files:
      - tests/busmaster_tb.sv

//--- busmaster.f
design/busmaster_pkg.sv
design/wb_if.sv
design/wb_priarbiter.sv
design/wb_busdelay.sv
design/wb_interconnect.sv
design/blk_ram.sv
design/fastio.sv
design/busmaster.sv
tests/busmaster_tb.sv

//--- design/blk_ram.sv
`timescale 1ns/1ps
`default_nettype none

module blk_ram #(
	parameter int LG_BLKRAM = busmaster_pkg::LG_BLKRAM
) (
	input wire i_clk,
	input wire i_stb,
	input wire i_we,
	input wire [LG_BLKRAM-1:0] i_addr,
	input wire [busmaster_pkg::DW-1:0] i_data,
	input wire [busmaster_pkg::SW-1:0] i_sel,
	output logic o_ack,
	output logic [busmaster_pkg::DW-1:0] o_data
);
	import busmaster_pkg::*;

	// Word storage
	logic [DW-1:0] mem [0:(1 << LG_BLKRAM)-1];

	// Byte lane writes
	always_ff @(posedge i_clk)
	begin
		if (i_stb && i_we)
		begin
			for (int b = 0; b < SW; b++)
			begin
				if (i_sel[b])
					mem[i_addr][8*b +: 8] <= i_data[8*b +: 8];
			end
		end
	end

	// Read on every strobe, old data on a write
	always_ff @(posedge i_clk)
	begin
		if (i_stb)
			o_data <= mem[i_addr];
	end

	// One cycle ack, never stalls
	// Strobe is held low through reset so this clears with it
	always_ff @(posedge i_clk)
		o_ack <= i_stb;

endmodule

`default_nettype wire

//--- design/busmaster.sv
`timescale 1ns/1ps
`default_nettype none

module busmaster (
	input wire i_clk,
	input wire i_rst,
	// Debug host port
	input wire i_dbg_cyc, i_dbg_stb, i_dbg_we,
	input wire [busmaster_pkg::AW-1:0] i_dbg_addr,
	input wire [busmaster_pkg::DW-1:0] i_dbg_data,
	input wire [busmaster_pkg::SW-1:0] i_dbg_sel,
	output logic o_dbg_ack, o_dbg_stall, o_dbg_err,
	output logic [busmaster_pkg::DW-1:0] o_dbg_data,
	// CPU port
	input wire i_cpu_cyc, i_cpu_stb, i_cpu_we,
	input wire [busmaster_pkg::AW-1:0] i_cpu_addr,
	input wire [busmaster_pkg::DW-1:0] i_cpu_data,
	input wire [busmaster_pkg::SW-1:0] i_cpu_sel,
	output logic o_cpu_ack, o_cpu_stall, o_cpu_err,
	output logic [busmaster_pkg::DW-1:0] o_cpu_data,
	// External DDR RAM
	output logic o_ram_cyc, o_ram_stb, o_ram_we,
	output logic [busmaster_pkg::RAM_AW-1:0] o_ram_addr,
	output logic [busmaster_pkg::DW-1:0] o_ram_wdata,
	output logic [busmaster_pkg::SW-1:0] o_ram_sel,
	input wire i_ram_ack, i_ram_stall, i_ram_err,
	input wire [busmaster_pkg::DW-1:0] i_ram_rdata,
	// Board I/O
	input wire [3:0] i_sw,
	input wire [3:0] i_btn,
	output logic [3:0] o_led
);
	import busmaster_pkg::*;

	wb_if dbg_bus ();
	wb_if cpu_bus ();
	wb_if arb_bus ();
	wb_if sys_bus ();

	// Slave side wires
	logic blk_stb, blk_ack, io_stb, io_ack;
	logic [DW-1:0] blk_data, io_data;
	logic [AW-1:0] err_addr, sys_addr_raw;

	//////////////////////////////////////////////////////////////////////
	// Master ports onto their buses
	//////////////////////////////////////////////////////////////////////

	assign dbg_bus.cyc = i_dbg_cyc;
	assign dbg_bus.stb = i_dbg_stb;
	assign dbg_bus.we = i_dbg_we;
	assign dbg_bus.addr = i_dbg_addr;
	assign dbg_bus.data_w = i_dbg_data;
	assign dbg_bus.sel = i_dbg_sel;
	assign o_dbg_ack = dbg_bus.ack;
	assign o_dbg_stall = dbg_bus.stall;
	assign o_dbg_err = dbg_bus.err;
	assign o_dbg_data = dbg_bus.data_r;

	assign cpu_bus.cyc = i_cpu_cyc;
	assign cpu_bus.stb = i_cpu_stb;
	assign cpu_bus.we = i_cpu_we;
	assign cpu_bus.addr = i_cpu_addr;
	assign cpu_bus.data_w = i_cpu_data;
	assign cpu_bus.sel = i_cpu_sel;
	assign o_cpu_ack = cpu_bus.ack;
	assign o_cpu_stall = cpu_bus.stall;
	assign o_cpu_err = cpu_bus.err;
	assign o_cpu_data = cpu_bus.data_r;

	//////////////////////////////////////////////////////////////////////
	// Arbiter, timing stage, decoder
	//////////////////////////////////////////////////////////////////////

	wb_priarbiter arbiter_i (.i_clk(i_clk), .i_rst(i_rst),
		.s_cpu(cpu_bus), .s_dbg(dbg_bus), .m(arb_bus));

	// Extra register stage between arbiter and decoder
	wb_busdelay delay_i (.i_clk(i_clk), .i_rst(i_rst),
		.s(arb_bus), .m(sys_bus));

	wb_interconnect interconnect_i (.i_clk(i_clk), .i_rst(i_rst), .s(sys_bus),
		.o_blk_stb(blk_stb), .o_io_stb(io_stb),
		.i_blk_ack(blk_ack), .i_io_ack(io_ack),
		.i_blk_data(blk_data), .i_io_data(io_data),
		.o_ram_cyc(o_ram_cyc), .o_ram_stb(o_ram_stb), .o_ram_we(o_ram_we),
		.o_ram_addr(o_ram_addr), .o_ram_wdata(o_ram_wdata), .o_ram_sel(o_ram_sel),
		.i_ram_ack(i_ram_ack), .i_ram_stall(i_ram_stall), .i_ram_err(i_ram_err),
		.i_ram_rdata(i_ram_rdata), .o_err_addr(err_addr));

	//////////////////////////////////////////////////////////////////////
	// Internal slaves
	//////////////////////////////////////////////////////////////////////

	assign sys_addr_raw = sys_bus.addr;

	blk_ram #(.LG_BLKRAM(LG_BLKRAM)) blk_ram_i (.i_clk(i_clk),
		.i_stb(blk_stb), .i_we(sys_bus.we),
		.i_addr(sys_addr_raw[LG_BLKRAM-1:0]), .i_data(sys_bus.data_w),
		.i_sel(sys_bus.sel), .o_ack(blk_ack), .o_data(blk_data));

	fastio fastio_i (.i_clk(i_clk), .i_rst(i_rst),
		.i_stb(io_stb), .i_we(sys_bus.we), .i_addr(sys_bus.addr),
		.i_data(sys_bus.data_w), .i_err_addr(err_addr),
		.i_sw(i_sw), .i_btn(i_btn), .o_led(o_led),
		.o_ack(io_ack), .o_data(io_data));

endmodule

`default_nettype wire

//--- design/busmaster_pkg.sv
`default_nettype none

package busmaster_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus widths
	//////////////////////////////////////////////////////////////////////

	// Word address, data and byte select widths
	localparam int AW = 28;
	localparam int DW = 32;
	localparam int SW = DW / 8;

	// External DDR RAM word address width
	localparam int RAM_AW = 26;

	// On-chip block RAM, log2 of its depth in words
	localparam int LG_BLKRAM = 10;

	//////////////////////////////////////////////////////////////////////
	// Fast I/O register map
	//////////////////////////////////////////////////////////////////////

	// Captured bus error address, read only
	localparam logic [4:0] IO_REG_ERRADDR = 5'd0;
	// Board LEDs
	localparam logic [4:0] IO_REG_LED = 5'd1;
	// Buttons and switches
	localparam logic [4:0] IO_REG_SWITCH = 5'd2;

	// I/O group holding the fast I/O block
	localparam logic [2:0] IO_GROUP = 3'd0;

	//////////////////////////////////////////////////////////////////////
	// Word address, two decodings of the same bits
	//////////////////////////////////////////////////////////////////////

	typedef union packed {
		// Region view, used by the address decoder
		struct packed {
			logic top;		// Above all regions, unmapped
			logic ram;		// External DDR RAM flag
			logic [9:0] ram_off;
			logic blk;		// Block RAM flag
			logic [5:0] blk_off;
			logic io;		// I/O page flag
			logic [2:0] group;
			logic [4:0] io_off;
		} region;
		// I/O view, used inside the fast I/O block
		struct packed {
			logic [22:0] upper;
			logic [4:0] idx;
		} io;
	} bus_addr_u;

endpackage

`default_nettype wire

//--- design/fastio.sv
`timescale 1ns/1ps
`default_nettype none

module fastio (
	input wire i_clk,
	input wire i_rst,
	input wire i_stb,
	input wire i_we,
	input wire busmaster_pkg::bus_addr_u i_addr,
	input wire [busmaster_pkg::DW-1:0] i_data,
	input wire [busmaster_pkg::AW-1:0] i_err_addr,
	input wire [3:0] i_sw,
	input wire [3:0] i_btn,
	output logic [3:0] o_led,
	output logic o_ack,
	output logic [busmaster_pkg::DW-1:0] o_data
);
	import busmaster_pkg::*;

	// Error address as a byte address
	logic [DW-1:0] err_byte_addr;

	assign err_byte_addr = {{(DW-AW-2){1'b0}}, i_err_addr, 2'b00};

	//////////////////////////////////////////////////////////////////////
	// Writes
	//////////////////////////////////////////////////////////////////////

	// LEDs, the only writable register
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_led <= 4'h0;
		else if (i_stb && i_we && (i_addr.io.idx == IO_REG_LED))
			o_led <= i_data[3:0];
	end

	//////////////////////////////////////////////////////////////////////
	// Reads
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		case (i_addr.io.idx)
			IO_REG_ERRADDR:
				o_data <= err_byte_addr;
			IO_REG_LED:
				o_data <= {{(DW-4){1'b0}}, o_led};
			IO_REG_SWITCH:
				o_data <= {{(DW-8){1'b0}}, i_btn, i_sw};
			default:
				o_data <= '0;
		endcase
	end

	// Single cycle ack, no stall
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_ack <= 1'b0;
		else
			o_ack <= i_stb;
	end

endmodule

`default_nettype wire

//--- design/wb_busdelay.sv
`timescale 1ns/1ps
`default_nettype none

module wb_busdelay (
	input wire i_clk,
	input wire i_rst,
	wb_if.slave s,
	wb_if.master m
);
	import busmaster_pkg::*;

	// Forward path registers
	logic r_cyc;
	logic r_stb;
	logic r_we;
	bus_addr_u r_addr;
	logic [DW-1:0] r_data_w;
	logic [SW-1:0] r_sel;

	// Return path registers
	logic r_ack;
	logic r_err;
	logic [DW-1:0] r_data_r;

	// Downstream refused the pending request
	logic hold;

	assign hold = r_stb && m.stall;

	//////////////////////////////////////////////////////////////////////
	// Forward, one cycle
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			r_cyc <= 1'b0;
		else
			r_cyc <= s.cyc;
	end

	// Dropping cyc abandons whatever is pending
	always_ff @(posedge i_clk)
	begin
		if (i_rst || !s.cyc)
			r_stb <= 1'b0;
		else if (!hold)
			r_stb <= s.stb;
	end

	always_ff @(posedge i_clk)
	begin
		if (!hold)
		begin
			r_we <= s.we;
			r_addr <= s.addr;
			r_data_w <= s.data_w;
			r_sel <= s.sel;
		end
	end

	assign m.cyc = r_cyc;
	assign m.stb = r_stb;
	assign m.we = r_we;
	assign m.addr = r_addr;
	assign m.data_w = r_data_w;
	assign m.sel = r_sel;

	// Upstream waits only while a request sits here unaccepted
	assign s.stall = hold;

	//////////////////////////////////////////////////////////////////////
	// Return, one cycle
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_rst || !s.cyc)
		begin
			r_ack <= 1'b0;
			r_err <= 1'b0;
		end
		else
		begin
			r_ack <= m.ack;
			r_err <= m.err;
		end
	end

	always_ff @(posedge i_clk)
		r_data_r <= m.data_r;

	assign s.ack = r_ack;
	assign s.err = r_err;
	assign s.data_r = r_data_r;

	// A stalled request stays put until downstream takes it
	a_stb_held: assert property (@(posedge i_clk) disable iff (i_rst)
		m.stb && m.stall && s.cyc |=> m.stb && $stable(m.addr));

endmodule

`default_nettype wire

//--- design/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
	import busmaster_pkg::*;

	// Request, from the master
	logic cyc;
	logic stb;
	logic we;
	bus_addr_u addr;
	logic [DW-1:0] data_w;
	logic [SW-1:0] sel;

	// Response, from the slave
	logic ack;
	logic stall;	// combinational
	logic err;
	logic [DW-1:0] data_r;

	// Master side drives the request
	modport master (
		output cyc, stb, we, addr, data_w, sel,
		input ack, stall, err, data_r
	);

	// Slave side drives the response
	modport slave (
		input cyc, stb, we, addr, data_w, sel,
		output ack, stall, err, data_r
	);

endinterface

`default_nettype wire

//--- design/wb_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module wb_interconnect (
	input wire i_clk,
	input wire i_rst,
	wb_if.slave s,
	// Internal slaves
	output logic o_blk_stb,
	output logic o_io_stb,
	input wire i_blk_ack,
	input wire i_io_ack,
	input wire [busmaster_pkg::DW-1:0] i_blk_data,
	input wire [busmaster_pkg::DW-1:0] i_io_data,
	// External DDR RAM
	output logic o_ram_cyc,
	output logic o_ram_stb,
	output logic o_ram_we,
	output logic [busmaster_pkg::RAM_AW-1:0] o_ram_addr,
	output logic [busmaster_pkg::DW-1:0] o_ram_wdata,
	output logic [busmaster_pkg::SW-1:0] o_ram_sel,
	input wire i_ram_ack,
	input wire i_ram_stall,
	input wire i_ram_err,
	input wire [busmaster_pkg::DW-1:0] i_ram_rdata,
	// Address of the last bus error
	output logic [busmaster_pkg::AW-1:0] o_err_addr
);
	import busmaster_pkg::*;

	// Region selects
	logic ram_sel, blk_sel, io_sel, none_sel;

	// Same address as a plain vector
	logic [AW-1:0] addr_raw;

	// Return path registers
	logic ack_r;
	logic err_r;
	logic [DW-1:0] data_r;

	// Address of the last accepted request
	logic [AW-1:0] last_addr;

	assign addr_raw = s.addr;

	//////////////////////////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////////////////////////

	// Priority by flag, RAM then block RAM then I/O page
	assign ram_sel = !s.addr.region.top && s.addr.region.ram;
	assign blk_sel = !s.addr.region.top && !s.addr.region.ram
		&& s.addr.region.blk;
	assign io_sel = !s.addr.region.top && !s.addr.region.ram
		&& !s.addr.region.blk && s.addr.region.io
		&& (s.addr.region.group == IO_GROUP);
	assign none_sel = !(ram_sel || blk_sel || io_sel);

	// Slave strobes, same cycle
	assign o_blk_stb = s.stb && blk_sel;
	assign o_io_stb = s.stb && io_sel;

	// DDR RAM port passes straight through
	assign o_ram_cyc = s.cyc;
	assign o_ram_stb = s.stb && ram_sel;
	assign o_ram_we = s.we;
	assign o_ram_addr = addr_raw[RAM_AW-1:0];
	assign o_ram_wdata = s.data_w;
	assign o_ram_sel = s.sel;

	// Only the DDR RAM can stall
	assign s.stall = ram_sel && i_ram_stall;

	//////////////////////////////////////////////////////////////////////
	// Registered acknowledge and data return
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			ack_r <= 1'b0;
		else
			ack_r <= s.cyc && (i_ram_ack || i_blk_ack || i_io_ack);
	end

	always_ff @(posedge i_clk)
	begin
		if (i_ram_ack)
			data_r <= i_ram_rdata;
		else if (i_blk_ack)
			data_r <= i_blk_data;
		else
			data_r <= i_io_data;
	end

	assign s.ack = ack_r;
	assign s.data_r = data_r;

	//////////////////////////////////////////////////////////////////////
	// Bus errors
	//////////////////////////////////////////////////////////////////////

	// Unmapped strobe, or an error passed on from the DDR RAM
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			err_r <= 1'b0;
		else
			err_r <= s.cyc && ((s.stb && none_sel) || i_ram_err);
	end

	assign s.err = err_r;

	always_ff @(posedge i_clk)
	begin
		if (s.stb && !s.stall)
			last_addr <= addr_raw;
	end

	// Capture on every error
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_err_addr <= '0;
		else if (err_r)
			o_err_addr <= last_addr;
	end

	// Every strobe lands on one slave or on the error path
	a_sel_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
		s.stb |-> $onehot({ram_sel, blk_sel, io_sel, none_sel}));

	// Slaves never answer together
	a_ack_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
		$onehot0({i_ram_ack, i_blk_ack, i_io_ack}));

endmodule

`default_nettype wire

//--- design/wb_priarbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_priarbiter (
	input wire i_clk,
	input wire i_rst,
	wb_if.slave s_cpu,
	wb_if.slave s_dbg,
	wb_if.master m
);

	// Ownership register, CPU by default
	logic cpu_owner;

	//////////////////////////////////////////////////////////////////////
	// Ownership
	//////////////////////////////////////////////////////////////////////

	// Back to the CPU as soon as the debug port lets go of cyc
	// Debug takes over only while the CPU is idle
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			cpu_owner <= 1'b1;
		else if (!s_dbg.cyc)
			cpu_owner <= 1'b1;
		else if (!s_cpu.cyc && s_dbg.stb)
			cpu_owner <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Request routing
	//////////////////////////////////////////////////////////////////////

	assign m.cyc = cpu_owner ? s_cpu.cyc : s_dbg.cyc;
	assign m.stb = cpu_owner ? s_cpu.stb : s_dbg.stb;
	assign m.we = cpu_owner ? s_cpu.we : s_dbg.we;
	assign m.addr = cpu_owner ? s_cpu.addr : s_dbg.addr;
	assign m.data_w = cpu_owner ? s_cpu.data_w : s_dbg.data_w;
	assign m.sel = cpu_owner ? s_cpu.sel : s_dbg.sel;

	// Response to the owner only, the loser just sees stall
	assign s_cpu.ack = cpu_owner && m.ack;
	assign s_cpu.err = cpu_owner && m.err;
	assign s_cpu.stall = !cpu_owner || m.stall;
	assign s_cpu.data_r = m.data_r;

	assign s_dbg.ack = !cpu_owner && m.ack;
	assign s_dbg.err = !cpu_owner && m.err;
	assign s_dbg.stall = cpu_owner || m.stall;
	assign s_dbg.data_r = m.data_r;

	// No hand-over in the middle of a bus cycle
	a_owner_held: assert property (@(posedge i_clk) disable iff (i_rst)
		m.cyc |=> $stable(cpu_owner));

endmodule

`default_nettype wire

//--- tests/busmaster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module busmaster_tb;
	import busmaster_pkg::*;

	// Master port numbers
	localparam int DBG = 0;
	localparam int CPU = 1;

	// Expected response of the request in flight
	localparam int K_NONE = 0;
	localparam int K_INT = 1;	// ack from block RAM or fast I/O
	localparam int K_MAP = 2;	// err from the decoder
	localparam int K_RAM = 3;
	localparam int K_RAMERR = 4;

	localparam int TIMEOUT = 50;

	// Addresses as the masters see them
	localparam logic [AW-1:0] BLK_BASE = 28'h0008000;
	localparam logic [AW-1:0] IO_BASE = 28'h0000100;
	localparam logic [AW-1:0] UNMAPPED = 28'h80000a4;
	localparam logic [AW-1:0] RAM_A = 28'h4000123;
	localparam logic [AW-1:0] RAM_B = 28'h7abcdef;

	logic i_clk, i_rst;
	// Master side signals indexed by DBG or CPU
	logic [1:0] m_cyc, m_stb, m_we;
	logic [AW-1:0] m_addr [2];
	logic [DW-1:0] m_data [2];
	logic [SW-1:0] m_sel [2];
	wire [1:0] p_ack, p_stall, p_err;
	wire [DW-1:0] p_data [2];
	// External RAM and board
	wire o_ram_cyc, o_ram_stb, o_ram_we;
	wire [RAM_AW-1:0] o_ram_addr;
	wire [DW-1:0] o_ram_wdata;
	wire [SW-1:0] o_ram_sel;
	logic i_ram_ack, i_ram_stall, i_ram_err;
	logic [DW-1:0] i_ram_rdata;
	logic [3:0] i_sw, i_btn;
	wire [3:0] o_led;

	// Reference state
	int exp_kind [2];
	logic exp_rd [2];
	logic [DW-1:0] exp_data [2];
	int age [2];
	logic idle_chk, led_chk, tie_chk, ram_err_next;
	logic [3:0] led_exp;
	logic [RAM_AW-1:0] ram_exp_addr;
	logic ram_exp_we;
	logic [DW-1:0] ram_exp_wdata;
	logic [SW-1:0] ram_exp_sel;
	logic [DW-1:0] blk_shadow [0:(1 << LG_BLKRAM)-1];
	logic [DW-1:0] ram_ref [logic [RAM_AW-1:0]];
	integer seed = 32'h771e_cd8d;

	initial
	begin
		i_clk = 1'b0;
		forever
			#5 i_clk = ~i_clk;
	end

	busmaster busmaster_i (.i_clk(i_clk), .i_rst(i_rst),
		.i_dbg_cyc(m_cyc[DBG]), .i_dbg_stb(m_stb[DBG]), .i_dbg_we(m_we[DBG]),
		.i_dbg_addr(m_addr[DBG]), .i_dbg_data(m_data[DBG]), .i_dbg_sel(m_sel[DBG]),
		.o_dbg_ack(p_ack[DBG]), .o_dbg_stall(p_stall[DBG]), .o_dbg_err(p_err[DBG]),
		.o_dbg_data(p_data[DBG]),
		.i_cpu_cyc(m_cyc[CPU]), .i_cpu_stb(m_stb[CPU]), .i_cpu_we(m_we[CPU]),
		.i_cpu_addr(m_addr[CPU]), .i_cpu_data(m_data[CPU]), .i_cpu_sel(m_sel[CPU]),
		.o_cpu_ack(p_ack[CPU]), .o_cpu_stall(p_stall[CPU]), .o_cpu_err(p_err[CPU]),
		.o_cpu_data(p_data[CPU]),
		.o_ram_cyc(o_ram_cyc), .o_ram_stb(o_ram_stb), .o_ram_we(o_ram_we),
		.o_ram_addr(o_ram_addr), .o_ram_wdata(o_ram_wdata), .o_ram_sel(o_ram_sel),
		.i_ram_ack(i_ram_ack), .i_ram_stall(i_ram_stall), .i_ram_err(i_ram_err),
		.i_ram_rdata(i_ram_rdata), .i_sw(i_sw), .i_btn(i_btn), .o_led(o_led));

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic fail_stop(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "Stopped at the first error");
	endtask

	function automatic string port_tag(input int p);
		return (p == CPU) ? "cpu" : "dbg";
	endfunction

	// Byte lanes of new_w where sel is set
	function automatic logic [DW-1:0] byte_merge(input logic [DW-1:0] old_w,
		input logic [DW-1:0] new_w, input logic [SW-1:0] sel);
		logic [DW-1:0] w;
		w = old_w;
		for (int b = 0; b < SW; b++)
		begin
			if (sel[b])
				w[8*b +: 8] = new_w[8*b +: 8];
		end
		return w;
	endfunction

	// Unwritten DDR words hold a pattern of their own address
	function automatic logic [DW-1:0] ram_lookup(input logic [RAM_AW-1:0] a);
		if (ram_ref.exists(a))
			return ram_ref[a];
		return {6'h2a, a};
	endfunction

	function automatic logic [AW-1:0] io_addr(input logic [4:0] idx);
		return {IO_BASE[AW-1:5], idx};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks sampled at the falling edge
	//////////////////////////////////////////////////////////////////////

	// Edges since acceptance counting from 1 at the negedge before the accepting edge
	always @(negedge i_clk)
	begin
		for (int p = 0; p < 2; p++)
		begin
			if (m_cyc[p] && m_stb[p] && !p_stall[p])
				age[p] <= 1;
			else
				age[p] <= age[p] + 1;
		end
	end

	for (genvar p = 0; p < 2; p++)
	begin : g_port
		a_ack_kind: assert property (@(negedge i_clk) disable iff (i_rst)
			p_ack[p] |-> (exp_kind[p] == K_INT || exp_kind[p] == K_RAM))
			else fail_stop($sformatf("Unexpected ack on the %s port at %0t",
				port_tag(p), $time));
		a_err_kind: assert property (@(negedge i_clk) disable iff (i_rst)
			p_err[p] |-> (exp_kind[p] == K_MAP || exp_kind[p] == K_RAMERR))
			else fail_stop($sformatf("Unexpected err on the %s port at %0t",
				port_tag(p), $time));
		// Four cycles for the internal slaves
		a_ack_lat: assert property (@(negedge i_clk) disable iff (i_rst)
			p_ack[p] && exp_kind[p] == K_INT |-> age[p] == 4)
			else fail_stop($sformatf("Mismatch at %0t: o_%s_ack latency expected 4, got %0d",
				$time, port_tag(p), $sampled(age[p])));
		// Three cycles for an unmapped access
		a_err_lat: assert property (@(negedge i_clk) disable iff (i_rst)
			p_err[p] && exp_kind[p] == K_MAP |-> age[p] == 3)
			else fail_stop($sformatf("Mismatch at %0t: o_%s_err latency expected 3, got %0d",
				$time, port_tag(p), $sampled(age[p])));
		a_rdata: assert property (@(negedge i_clk) disable iff (i_rst)
			p_ack[p] && exp_rd[p] |-> p_data[p] == exp_data[p])
			else fail_stop($sformatf("Mismatch at %0t: o_%s_data expected %h, got %h",
				$time, port_tag(p), exp_data[p], p_data[p]));
	end

	a_idle: assert property (@(negedge i_clk) disable iff (i_rst)
		idle_chk |-> p_ack == 2'b00 && p_err == 2'b00 && !o_ram_cyc && !o_ram_stb
			&& o_led == 4'h0)
		else fail_stop($sformatf(
			"Mismatch at %0t: idle ack %b err %b o_ram_cyc %b o_ram_stb %b o_led %h, expected 0",
			$time, p_ack, p_err, o_ram_cyc, o_ram_stb, o_led));
	a_led: assert property (@(negedge i_clk) disable iff (i_rst)
		led_chk |-> o_led == led_exp)
		else fail_stop($sformatf("Mismatch at %0t: o_led expected %h, got %h",
			$time, led_exp, o_led));
	// DDR RAM cycle stays open from the strobe until its answer
	a_ram_cyc: assert property (@(negedge i_clk) disable iff (i_rst)
		o_ram_stb || i_ram_ack || i_ram_err |-> o_ram_cyc)
		else fail_stop($sformatf("Mismatch at %0t: o_ram_cyc expected 1, got %b",
			$time, o_ram_cyc));
	a_ram_addr: assert property (@(negedge i_clk) disable iff (i_rst)
		o_ram_stb |-> o_ram_addr == ram_exp_addr)
		else fail_stop($sformatf("Mismatch at %0t: o_ram_addr expected %h, got %h",
			$time, ram_exp_addr, o_ram_addr));
	a_ram_we: assert property (@(negedge i_clk) disable iff (i_rst)
		o_ram_stb |-> o_ram_we == ram_exp_we)
		else fail_stop($sformatf("Mismatch at %0t: o_ram_we expected %b, got %b",
			$time, ram_exp_we, o_ram_we));
	a_ram_wdata: assert property (@(negedge i_clk) disable iff (i_rst)
		o_ram_stb && o_ram_we |-> o_ram_wdata == ram_exp_wdata)
		else fail_stop($sformatf("Mismatch at %0t: o_ram_wdata expected %h, got %h",
			$time, ram_exp_wdata, o_ram_wdata));
	a_ram_sel: assert property (@(negedge i_clk) disable iff (i_rst)
		o_ram_stb |-> o_ram_sel == ram_exp_sel)
		else fail_stop($sformatf("Mismatch at %0t: o_ram_sel expected %b, got %b",
			$time, ram_exp_sel, o_ram_sel));
	// CPU wins the tie and keeps the bus for its whole cycle
	a_tie_stall: assert property (@(negedge i_clk) disable iff (i_rst)
		tie_chk && m_cyc[CPU] |-> p_stall[DBG])
		else fail_stop($sformatf("Mismatch at %0t: o_dbg_stall expected 1, got %b",
			$time, p_stall[DBG]));

	//////////////////////////////////////////////////////////////////////
	// Masters
	//////////////////////////////////////////////////////////////////////

	// One single access that waits for acceptance and then for ack or err
	task automatic bus_access(input int p, input logic we, input logic [AW-1:0] addr,
		input logic [DW-1:0] wdata, input logic [SW-1:0] sel, input int kind,
		input logic [DW-1:0] rexp);
		int n;
		@(posedge i_clk);
		#1;
		exp_kind[p] = kind;
		exp_rd[p] = !we && (kind == K_INT || kind == K_RAM);
		exp_data[p] = rexp;
		m_cyc[p] = 1'b1;
		m_stb[p] = 1'b1;
		m_we[p] = we;
		m_addr[p] = addr;
		m_data[p] = wdata;
		m_sel[p] = sel;
		n = 0;
		do
		begin
			@(negedge i_clk);
			n++;
			if (n > TIMEOUT)
				fail_stop($sformatf("The %s port request was not accepted in %0d cycles",
					port_tag(p), TIMEOUT));
		end
		while (p_stall[p]);
		// Accepted on this edge
		@(posedge i_clk);
		#1;
		m_stb[p] = 1'b0;
		n = 0;
		do
		begin
			@(negedge i_clk);
			n++;
			if (n > TIMEOUT)
				fail_stop($sformatf("No ack or err on the %s port in %0d cycles",
					port_tag(p), TIMEOUT));
		end
		while (!p_ack[p] && !p_err[p]);
		@(posedge i_clk);
		#1;
		m_cyc[p] = 1'b0;
		exp_kind[p] = K_NONE;
		exp_rd[p] = 1'b0;
	endtask

	task automatic blk_write(input int p, input logic [LG_BLKRAM-1:0] idx,
		input logic [DW-1:0] data, input logic [SW-1:0] sel);
		blk_shadow[idx] = byte_merge(blk_shadow[idx], data, sel);
		bus_access(p, 1'b1, {BLK_BASE[AW-1:LG_BLKRAM], idx}, data, sel, K_INT, '0);
	endtask

	task automatic blk_read(input int p, input logic [LG_BLKRAM-1:0] idx);
		bus_access(p, 1'b0, {BLK_BASE[AW-1:LG_BLKRAM], idx}, '0, 4'hf, K_INT,
			blk_shadow[idx]);
	endtask

	//////////////////////////////////////////////////////////////////////
	// External DDR RAM model
	//////////////////////////////////////////////////////////////////////

	initial
	begin : ram_model
		int delay;
		logic we;
		logic [RAM_AW-1:0] addr;
		logic [DW-1:0] wdata;
		logic [SW-1:0] sel;
		i_ram_ack = 1'b0;
		i_ram_stall = 1'b0;
		i_ram_err = 1'b0;
		i_ram_rdata = '0;
		forever
		begin
			@(negedge i_clk);
			if (o_ram_stb)
			begin
				we = o_ram_we;
				addr = o_ram_addr;
				wdata = o_ram_wdata;
				sel = o_ram_sel;
				delay = $unsigned($random(seed)) % 4;
				// Accepting edge followed by a random wait
				@(posedge i_clk);
				repeat (delay) @(posedge i_clk);
				#1;
				if (ram_err_next)
				begin
					i_ram_err = 1'b1;
					ram_err_next = 1'b0;
				end
				else
				begin
					if (we)
						ram_ref[addr] = byte_merge(ram_lookup(addr), wdata, sel);
					else
						i_ram_rdata = ram_lookup(addr);
					i_ram_ack = 1'b1;
				end
				@(posedge i_clk);
				#1;
				i_ram_ack = 1'b0;
				i_ram_err = 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		m_cyc = '0;
		m_stb = '0;
		m_we = '0;
		for (int p = 0; p < 2; p++)
		begin
			m_addr[p] = '0;
			m_data[p] = '0;
			m_sel[p] = '0;
			exp_kind[p] = K_NONE;
			exp_rd[p] = 1'b0;
			exp_data[p] = '0;
			age[p] = 0;
		end
		i_sw = 4'h0;
		i_btn = 4'h0;
		idle_chk = 1'b0;
		led_chk = 1'b0;
		tie_chk = 1'b0;
		ram_err_next = 1'b0;
		led_exp = 4'h0;
		ram_exp_addr = '0;
		ram_exp_we = 1'b0;
		ram_exp_wdata = '0;
		ram_exp_sel = '0;
		i_rst = 1'b1;
		repeat (2) @(posedge i_clk);
		#1;
		i_rst = 1'b0;

		// Quiet bus straight after reset
		idle_chk = 1'b1;
		repeat (8) @(posedge i_clk);
		#1;
		idle_chk = 1'b0;

		// Partial block RAM write merged into a full word
		blk_write(CPU, 10'h010, 32'h1122_3344, 4'hf);
		blk_write(DBG, 10'h010, 32'haabb_ccdd, 4'b0101);
		blk_read(DBG, 10'h010);

		// DDR RAM pass-through followed by a passed-on error
		ram_exp_addr = RAM_A[RAM_AW-1:0];
		ram_exp_we = 1'b1;
		ram_exp_wdata = 32'hcafe_f00d;
		ram_exp_sel = 4'b1011;
		bus_access(DBG, 1'b1, RAM_A, 32'hcafe_f00d, 4'b1011, K_RAM, '0);
		ram_exp_we = 1'b0;
		ram_exp_sel = 4'hf;
		bus_access(CPU, 1'b0, RAM_A, '0, 4'hf, K_RAM, ram_lookup(RAM_A[RAM_AW-1:0]));
		ram_exp_addr = RAM_B[RAM_AW-1:0];
		bus_access(DBG, 1'b0, RAM_B, '0, 4'hf, K_RAM, ram_lookup(RAM_B[RAM_AW-1:0]));
		ram_err_next = 1'b1;
		bus_access(CPU, 1'b0, RAM_B, '0, 4'hf, K_RAMERR, '0);

		// LEDs followed by switches and buttons
		bus_access(DBG, 1'b1, io_addr(IO_REG_LED), 32'h0000_00a5, 4'hf, K_INT, '0);
		led_exp = 4'h5;
		led_chk = 1'b1;
		bus_access(CPU, 1'b0, io_addr(IO_REG_LED), '0, 4'hf, K_INT, {28'h0, led_exp});
		i_sw = 4'h9;
		i_btn = 4'h6;
		bus_access(CPU, 1'b0, io_addr(IO_REG_SWITCH), '0, 4'hf, K_INT, 32'h0000_0069);

		// Unmapped access and its captured byte address
		bus_access(DBG, 1'b0, UNMAPPED, '0, 4'hf, K_MAP, '0);
		bus_access(CPU, 1'b0, io_addr(IO_REG_ERRADDR), '0, 4'hf, K_INT,
			DW'(UNMAPPED) * 4);

		// Both ports in the same cycle
		blk_write(CPU, 10'h030, 32'h5a5a_0f0f, 4'hf);
		tie_chk = 1'b1;
		fork
			blk_read(CPU, 10'h010);
			blk_read(DBG, 10'h030);
		join
		tie_chk = 1'b0;

		repeat (2) @(posedge i_clk);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire
